// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = wiscDecodeTb
FILELIST  = wiscDecode.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== include/wiscDecode_config.svh ====
`ifndef WISCDECODE_CONFIG_SVH
`define WISCDECODE_CONFIG_SVH

// Data and PC width in bits
`define WORD_WIDTH 16

// Architectural registers, R0 is an ordinary register in this ISA
`define REG_COUNT 8

// JAL and JALR return their link value through this register
`define LINK_REG 7

// Instructions are two bytes apart
`define PC_STEP 2

`endif

// ==== source/branchResolve.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wiscDecode_config.svh"

module branchResolve (
   input  isaPkg::word_t   pc,
   input  isaPkg::opcode_t opcode,
   input  isaPkg::word_t   rsValue,
   input  isaPkg::word_t   immediate,
   output logic            taken,
   output isaPkg::word_t   nextPc,
   output isaPkg::word_t   pcPlusStep
);
   import isaPkg::*;

   branchCond_t cond;
   logic        rsZero;
   logic        rsNegative;
   logic        condMet;
   word_t       pcRelTarget;
   word_t       regTarget;

   assign rsZero     = (rsValue == '0);
   assign rsNegative = rsValue[`WORD_WIDTH-1];   // Two's complement sign

   // Low two opcode bits name the condition of a branch
   assign cond = branchCond_t'(opcode[1:0]);

   always_comb begin
      case (cond)
         EQZ: condMet = rsZero;
         NEZ: condMet = !rsZero;
         LTZ: condMet = rsNegative;
         GEZ: condMet = !rsNegative;
         default: condMet = 1'b0;
      endcase
   end

   // The three target adders
   assign pcPlusStep  = pc + word_t'(`PC_STEP);
   assign pcRelTarget = pcPlusStep + immediate;   // Branches, J and JAL
   assign regTarget   = rsValue + immediate;      // JR and JALR

   assign taken = (isBranch(opcode) && condMet) || isJump(opcode);

   always_comb begin
      if (isBranch(opcode) && condMet)
         nextPc = pcRelTarget;
      else if (opcode == J || opcode == JAL)
         nextPc = pcRelTarget;                    // Immediate holds the 11-bit displacement
      else if (opcode == JR || opcode == JALR)
         nextPc = regTarget;
      else
         nextPc = pcPlusStep;                     // Fall-through
   end

endmodule

`default_nettype wire

// ==== source/decodeControl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wiscDecode_config.svh"

module decodeControl (
   input  logic                   clk,
   input  logic                   arstN,
   input  pipePkg::fetchBundle_t  inBundle,
   input  logic                   inValid,
   output logic                   inReady,
   output pipePkg::decodedBundle_t outBundle,
   output logic                   outValid,
   input  logic                   outReady,
   output isaPkg::regAddr_t       rsAddr,
   output isaPkg::regAddr_t       rtAddr,
   input  isaPkg::word_t          rsValue,
   input  isaPkg::word_t          rtValue,
   output isaPkg::word_t          immediate,
   output isaPkg::opcode_t        opcode,
   input  logic                   taken,
   input  isaPkg::word_t          nextPc,
   input  isaPkg::word_t          pcPlusStep
);
   import isaPkg::*;
   import pipePkg::*;

   typedef enum logic {RUN, HALTED} runState_t;

   runState_t      state;
   instr_t         instr;
   regAddr_t       destReg;
   logic           destWrite;
   logic           accept;
   decodedBundle_t nextBundle;

   assign instr  = inBundle.instr;
   assign opcode = opcode_t'(instr[15:11]);   // Unlisted encodings fall through as NOP
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];

   // Destination and immediate depend on the instruction format
   always_comb begin
      destReg   = '0;
      destWrite = 1'b0;
      immediate = '0;
      case (opcode)
         ADD, SUB: begin
            destReg   = instr[4:2];   // Register format writes Rd
            destWrite = 1'b1;
         end
         ADDI, SUBI: begin
            destReg   = rtAddr;
            destWrite = 1'b1;
            immediate = {{(`WORD_WIDTH-5){instr[4]}}, instr[4:0]};
         end
         LBI: begin
            destReg   = rsAddr;       // LBI loads into Rs itself
            destWrite = 1'b1;
            immediate = {{(`WORD_WIDTH-8){instr[7]}}, instr[7:0]};
         end
         BEQZ, BNEZ, BLTZ, BGEZ, JR: begin
            immediate = {{(`WORD_WIDTH-8){instr[7]}}, instr[7:0]};
         end
         JALR: begin
            destReg   = regAddr_t'(`LINK_REG);
            destWrite = 1'b1;
            immediate = {{(`WORD_WIDTH-8){instr[7]}}, instr[7:0]};
         end
         J: immediate = {{(`WORD_WIDTH-11){instr[10]}}, instr[10:0]};
         JAL: begin
            destReg   = regAddr_t'(`LINK_REG);
            destWrite = 1'b1;
            immediate = {{(`WORD_WIDTH-11){instr[10]}}, instr[10:0]};
         end
         default: ;                   // NOP and HALT carry nothing
      endcase
   end

   always_comb begin
      nextBundle.opcode    = opcode;
      nextBundle.destReg   = destReg;
      nextBundle.destWrite = destWrite;
      nextBundle.rsValue   = rsValue;
      nextBundle.rtValue   = rtValue;
      nextBundle.immediate = immediate;
      // The link write happens later through writeback, not here
      nextBundle.linkValue = isLink(opcode) ? pcPlusStep : '0;
      nextBundle.taken     = taken;
      nextBundle.nextPc    = nextPc;
      nextBundle.halt      = (opcode == HALT);
   end

   // One-deep output register, refilled in the same cycle it drains
   assign inReady = (state == RUN) && (!outValid || outReady);
   assign accept  = inValid && inReady;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= RUN;
         outValid <= 1'b0;
      end else begin
         if (accept && nextBundle.halt)
            state <= HALTED;          // Sticky until the next reset
         if (accept)
            outValid <= 1'b1;
         else if (outReady)
            outValid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         outBundle <= nextBundle;
   end

   // A HALT closes the input from the following cycle on
   haltClosesInput: assert property (@(posedge clk) disable iff (!arstN)
      accept && nextBundle.halt |=> state == HALTED && !inReady);

   haltIsSticky: assert property (@(posedge clk) disable iff (!arstN)
      state == HALTED |=> state == HALTED && !inReady);

   // Execute must see the same bundle until it takes it
   outHoldsUnderStall: assert property (@(posedge clk) disable iff (!arstN)
      outValid && !outReady |=> outValid && $stable(outBundle));

endmodule

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

`include "wiscDecode_config.svh"

package isaPkg;

   typedef logic [`WORD_WIDTH-1:0] word_t;              // One data word or one PC value
   typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;    // Register index
   typedef logic [15:0] instr_t;                        // Raw instruction, fixed by the ISA

   // Major opcode in bits 15 to 11
   // Register-format arithmetic gets its own opcode per operation
   typedef enum logic [4:0] {
      HALT = 5'b00000,
      NOP  = 5'b00001,
      J    = 5'b00100,    // PC-relative, 11-bit displacement
      JR   = 5'b00101,    // Rs plus 8-bit immediate
      JAL  = 5'b00110,
      JALR = 5'b00111,
      ADDI = 5'b01000,
      SUBI = 5'b01001,
      BEQZ = 5'b01100,    // The four branches share bits 15 to 13
      BNEZ = 5'b01101,
      BLTZ = 5'b01110,
      BGEZ = 5'b01111,
      LBI  = 5'b11000,
      SUB  = 5'b11010,
      ADD  = 5'b11011
   } opcode_t;

   // Branch condition held in bits 12 to 11 of a branch opcode
   typedef enum logic [1:0] {
      EQZ = 2'b00,
      NEZ = 2'b01,
      LTZ = 2'b10,
      GEZ = 2'b11
   } branchCond_t;

   // Conditional branches, taken only when the condition holds
   function automatic logic isBranch(opcode_t op);
      return op inside {BEQZ, BNEZ, BLTZ, BGEZ};
   endfunction

   // Unconditional control transfers
   function automatic logic isJump(opcode_t op);
      return op inside {J, JAL, JR, JALR};
   endfunction

   // Jumps that leave PC+2 behind in the link register
   function automatic logic isLink(opcode_t op);
      return op inside {JAL, JALR};
   endfunction

endpackage

`default_nettype wire

// ==== source/operandForward.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandForward (
   input  isaPkg::regAddr_t    rsAddr,
   input  isaPkg::regAddr_t    rtAddr,
   input  isaPkg::word_t       rsFile,
   input  isaPkg::word_t       rtFile,
   input  pipePkg::forwardSrc_t exForward,
   input  pipePkg::forwardSrc_t memForward,
   output isaPkg::word_t       rsValue,
   output isaPkg::word_t       rtValue
);
   import isaPkg::*;

   // The youngest result wins, so execute beats memory beats the file
   function automatic word_t pickOperand(regAddr_t addr, word_t fileValue);
      if (exForward.valid && exForward.regAddr == addr)
         return exForward.value;
      else if (memForward.valid && memForward.regAddr == addr)
         return memForward.value;
      return fileValue;
   endfunction

   assign rsValue = pickOperand(rsAddr, rsFile);
   assign rtValue = pickOperand(rtAddr, rtFile);

   // A valid forward with X data would corrupt the operand silently
   always_comb begin
      if (exForward.valid)
         assert (!$isunknown(exForward.value))
            else $error("Unknown value on valid execute forward");
      if (memForward.valid)
         assert (!$isunknown(memForward.value))
            else $error("Unknown value on valid memory forward");
   end

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
`default_nettype none

package pipePkg;

   // Fetch to decode, one instruction and the PC it was fetched from
   typedef struct packed {
      isaPkg::instr_t instr;
      isaPkg::word_t  pc;
   } fetchBundle_t;

   // Result that a later stage is about to write back
   typedef struct packed {
      logic             valid;     // Clear when the stage holds no register result
      isaPkg::regAddr_t regAddr;
      isaPkg::word_t    value;
   } forwardSrc_t;

   // Register file write from writeback
   typedef struct packed {
      logic             enable;
      isaPkg::regAddr_t addr;
      isaPkg::word_t    data;
   } wbWrite_t;

   // Decode to execute
   // Taken and nextPc are also what fetch needs for redirection
   typedef struct packed {
      isaPkg::opcode_t  opcode;
      isaPkg::regAddr_t destReg;
      logic             destWrite;   // Instruction writes destReg on retirement
      isaPkg::word_t    rsValue;     // Forwarded operands
      isaPkg::word_t    rtValue;
      isaPkg::word_t    immediate;   // Already sign-extended for its format
      isaPkg::word_t    linkValue;   // PC+2 for JAL and JALR, zero otherwise
      logic             taken;
      isaPkg::word_t    nextPc;
      logic             halt;
   } decodedBundle_t;

endpackage

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wiscDecode_config.svh"

module regFile (
   input  logic              clk,
   input  logic              arstN,
   input  pipePkg::wbWrite_t wbWrite,
   input  isaPkg::regAddr_t  rsAddr,
   input  isaPkg::regAddr_t  rtAddr,
   output isaPkg::word_t     rsData,
   output isaPkg::word_t     rtData
);
   import isaPkg::*;

   word_t regs [`REG_COUNT];

   // All registers start at zero, R0 included
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end else if (wbWrite.enable) begin
         regs[wbWrite.addr] <= wbWrite.data;
      end
   end

   // Write-through lets decode read a value retiring in this same cycle
   always_comb begin
      if (wbWrite.enable && wbWrite.addr == rsAddr)
         rsData = wbWrite.data;
      else
         rsData = regs[rsAddr];
   end

   always_comb begin
      if (wbWrite.enable && wbWrite.addr == rtAddr)
         rtData = wbWrite.data;
      else
         rtData = regs[rtAddr];
   end

   // Every address takes a write, register 0 is not hardwired
   writeLands: assert property (@(posedge clk) disable iff (!arstN)
      wbWrite.enable |=> regs[$past(wbWrite.addr)] == $past(wbWrite.data));

endmodule

`default_nettype wire

// ==== source/wiscDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module wiscDecode (
   input  logic                    clk,
   input  logic                    arstN,
   input  pipePkg::fetchBundle_t   inBundle,
   input  logic                    inValid,
   output logic                    inReady,
   output pipePkg::decodedBundle_t outBundle,
   output logic                    outValid,
   input  logic                    outReady,
   input  pipePkg::forwardSrc_t    exForward,
   input  pipePkg::forwardSrc_t    memForward,
   input  pipePkg::wbWrite_t       wbWrite
);
   import isaPkg::*;

   regAddr_t rsAddr;
   regAddr_t rtAddr;
   word_t    rsFile;       // Register file read data before forwarding
   word_t    rtFile;
   word_t    rsValue;      // Operands after forwarding
   word_t    rtValue;
   word_t    immediate;
   opcode_t  opcode;
   logic     taken;
   word_t    nextPc;
   word_t    pcPlusStep;

   decodeControl u_decodeControl (
      .clk        (clk),
      .arstN      (arstN),
      .inBundle   (inBundle),
      .inValid    (inValid),
      .inReady    (inReady),
      .outBundle  (outBundle),
      .outValid   (outValid),
      .outReady   (outReady),
      .rsAddr     (rsAddr),
      .rtAddr     (rtAddr),
      .rsValue    (rsValue),
      .rtValue    (rtValue),
      .immediate  (immediate),
      .opcode     (opcode),
      .taken      (taken),
      .nextPc     (nextPc),
      .pcPlusStep (pcPlusStep)
   );

   regFile u_regFile (
      .clk     (clk),
      .arstN   (arstN),
      .wbWrite (wbWrite),
      .rsAddr  (rsAddr),
      .rtAddr  (rtAddr),
      .rsData  (rsFile),
      .rtData  (rtFile)
   );

   operandForward u_operandForward (
      .rsAddr     (rsAddr),
      .rtAddr     (rtAddr),
      .rsFile     (rsFile),
      .rtFile     (rtFile),
      .exForward  (exForward),
      .memForward (memForward),
      .rsValue    (rsValue),
      .rtValue    (rtValue)
   );

   // Branches test the forwarded Rs, not the stale file value
   branchResolve u_branchResolve (
      .pc         (inBundle.pc),
      .opcode     (opcode),
      .rsValue    (rsValue),
      .immediate  (immediate),
      .taken      (taken),
      .nextPc     (nextPc),
      .pcPlusStep (pcPlusStep)
   );

endmodule

`default_nettype wire

// ==== testbench/wiscDecodeTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wiscDecode_config.svh"

module wiscDecodeTb;
   import isaPkg::*;
   import pipePkg::*;

   logic           clk;
   logic           arstN;
   fetchBundle_t   inBundle;
   logic           inValid;
   logic           inReady;
   decodedBundle_t outBundle;
   logic           outValid;
   logic           outReady;
   forwardSrc_t    exForward;
   forwardSrc_t    memForward;
   wbWrite_t       wbWrite;

   int unsigned    lcgState = 5086;
   word_t          modelRegs [`REG_COUNT];   // Register state as the testbench tracks it
   decodedBundle_t expQ [$];                 // Accepted and not yet delivered, oldest first
   logic           haltSeen = 1'b0;          // Set once a HALT has been accepted
   int             valueErrors = 0;
   int             otherErrors = 0;
   int             inCount = 0;
   int             outCount = 0;
   int             cycles = 0;

   wiscDecode u_wiscDecode (
      .clk        (clk),
      .arstN      (arstN),
      .inBundle   (inBundle),
      .inValid    (inValid),
      .inReady    (inReady),
      .outBundle  (outBundle),
      .outValid   (outValid),
      .outReady   (outReady),
      .exForward  (exForward),
      .memForward (memForward),
      .wbWrite    (wbWrite)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Upper half of a 32-bit LCG, its low bits repeat too soon
   function automatic logic [15:0] nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[31:16];
   endfunction

   function automatic logic chance(int unsigned percent);
      int unsigned roll;
      roll = 32'(nextRandom()) % 32'd100;
      return roll < percent;
   endfunction

   // Zero shows up often enough that EQZ and NEZ both go each way
   function automatic word_t randomValue();
      word_t v;
      v = word_t'(nextRandom());
      return chance(25) ? '0 : v;
   endfunction

   function automatic opcode_t randomOpcode();
      logic [3:0] sel;
      sel = 4'(nextRandom() % 16'd14);
      case (sel)
         4'd0:  return ADD;
         4'd1:  return SUB;
         4'd2:  return ADDI;
         4'd3:  return SUBI;
         4'd4:  return LBI;
         4'd5:  return BEQZ;
         4'd6:  return BNEZ;
         4'd7:  return BLTZ;
         4'd8:  return BGEZ;
         4'd9:  return J;
         4'd10: return JAL;
         4'd11: return JR;
         4'd12: return NOP;
         default: return JALR;
      endcase
   endfunction

   // Left-align the field, then shift back arithmetically to copy its top bit
   function automatic word_t signExtend(logic [10:0] field, int unsigned bits);
      word_t w;
      w = {{(`WORD_WIDTH-11){1'b0}}, field} << (`WORD_WIDTH - bits);
      return $signed(w) >>> (`WORD_WIDTH - bits);
   endfunction

   // Execute beats memory, memory beats a same-cycle writeback, which beats the array
   function automatic word_t operandOf(regAddr_t a);
      if (exForward.valid && exForward.regAddr == a) return exForward.value;
      if (memForward.valid && memForward.regAddr == a) return memForward.value;
      if (wbWrite.enable && wbWrite.addr == a) return wbWrite.data;
      return modelRegs[a];
   endfunction

   function automatic decodedBundle_t expectedBundle(fetchBundle_t b);
      decodedBundle_t e;
      opcode_t        op;
      word_t          pcNext;
      logic           condHolds;
      op        = opcode_t'(b.instr[15:11]);
      pcNext    = b.pc + word_t'(`PC_STEP);
      e         = '0;
      e.opcode  = op;
      e.rsValue = operandOf(b.instr[10:8]);
      e.rtValue = operandOf(b.instr[7:5]);
      e.nextPc  = pcNext;                     // Fall-through unless a transfer below
      e.halt    = (op == HALT);
      condHolds = (op == BEQZ && e.rsValue == '0) || (op == BNEZ && e.rsValue != '0)
                  || (op == BLTZ && e.rsValue[`WORD_WIDTH-1])
                  || (op == BGEZ && !e.rsValue[`WORD_WIDTH-1]);
      if (op == ADD || op == SUB) begin
         e.destReg   = b.instr[4:2];
         e.destWrite = 1'b1;
      end else if (op == ADDI || op == SUBI) begin
         e.destReg   = b.instr[7:5];          // Immediate format writes Rt
         e.destWrite = 1'b1;
         e.immediate = signExtend(b.instr[10:0], 5);
      end else if (op == LBI) begin
         e.destReg   = b.instr[10:8];
         e.destWrite = 1'b1;
         e.immediate = signExtend(b.instr[10:0], 8);
      end else if (op == J || op == JAL) begin
         e.immediate = signExtend(b.instr[10:0], 11);
         e.nextPc    = pcNext + e.immediate;
      end else if (op == JR || op == JALR) begin
         e.immediate = signExtend(b.instr[10:0], 8);
         e.nextPc    = e.rsValue + e.immediate;
      end else if (op inside {BEQZ, BNEZ, BLTZ, BGEZ}) begin
         e.immediate = signExtend(b.instr[10:0], 8);
         if (condHolds) e.nextPc = pcNext + e.immediate;
      end
      e.taken = condHolds || (op inside {J, JAL, JR, JALR});
      if (op == JAL || op == JALR) begin
         e.destReg   = regAddr_t'(`LINK_REG);
         e.destWrite = 1'b1;
         e.linkValue = pcNext;
      end
      return e;
   endfunction

   task automatic checkBundle(string name, decodedBundle_t expected, decodedBundle_t actual);
      if (actual !== expected) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic checkWord(string name, word_t expected, word_t actual);
      if (actual !== expected) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic checkFlag(string name, logic expected, logic actual);
      if (actual !== expected) begin
         $display("ERR %s expected %b actual %b", name, expected, actual);
         valueErrors++;
      end
   endtask

   // Called right after a falling edge, all values hold until the rising edge
   task automatic driveRandom(logic sendHalt, logic valid, logic ready);
      inBundle.instr       = {sendHalt ? HALT : randomOpcode(), 11'(nextRandom())};
      inBundle.pc          = word_t'(nextRandom()) & 16'hfffe;
      inValid              = valid;
      outReady             = ready;
      exForward.valid      = chance(40);
      exForward.regAddr    = regAddr_t'(nextRandom());
      exForward.value      = randomValue();
      memForward.valid     = chance(40);
      memForward.regAddr   = regAddr_t'(nextRandom());
      memForward.value     = randomValue();
      wbWrite.enable       = chance(50);
      wbWrite.addr         = regAddr_t'(nextRandom());
      wbWrite.data         = randomValue();
   endtask

   // Settles the inputs, then books what the coming rising edge will transfer
   task automatic observeCycle();
      decodedBundle_t want;
      logic           wantOutValid;
      logic           wantInReady;
      #1;
      // One bundle at most is in flight, and a HALT closes the input for good
      wantOutValid = (expQ.size() != 0);
      wantInReady  = !haltSeen && (!wantOutValid || outReady);
      checkFlag($sformatf("outValid cycle %0d", cycles), wantOutValid, outValid);
      checkFlag($sformatf("inReady cycle %0d", cycles), wantInReady, inReady);
      cycles++;
      if (outValid && outReady) begin
         if (expQ.size() == 0) begin
            $display("Output transfer with no instruction outstanding");
            otherErrors++;
         end else begin
            want = expQ.pop_front();
            checkWord($sformatf("nextPc %0d", outCount), want.nextPc, outBundle.nextPc);
            checkWord($sformatf("linkValue %0d", outCount), want.linkValue, outBundle.linkValue);
            checkBundle($sformatf("bundle %0d", outCount), want, outBundle);
            outCount++;
         end
      end
      if (inValid && inReady) begin
         expQ.push_back(expectedBundle(inBundle));
         inCount++;
         if (inBundle.instr[15:11] == HALT) haltSeen = 1'b1;
      end
      if (wbWrite.enable) modelRegs[wbWrite.addr] = wbWrite.data;
   endtask

   initial begin
      int waited;
      arstN      = 1'b0;
      inBundle   = '0;
      inValid    = 1'b0;
      outReady   = 1'b0;
      exForward  = '0;
      memForward = '0;
      wbWrite    = '0;
      for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      #1;
      if (outValid !== 1'b0 || inReady !== 1'b1) begin
         $display("After reset outValid is not low or inReady is not high");
         otherErrors++;
      end
      for (int n = 0; n < 600; n++) begin   // Mixed traffic with random stalls on both sides
         @(negedge clk);
         driveRandom(1'b0, chance(70), chance(60));
         observeCycle();
      end
      waited = 0;
      while (!haltSeen && waited < 100) begin
         @(negedge clk);
         driveRandom(1'b1, 1'b1, chance(60));
         observeCycle();
         waited++;
      end
      if (!haltSeen) begin
         $display("Timed out waiting for the HALT to be accepted");
         otherErrors++;
      end
      for (int n = 0; n < 300; n++) begin   // Input offered every cycle, must never be taken
         @(negedge clk);
         driveRandom(1'b0, 1'b1, chance(50));
         observeCycle();
      end
      waited = 0;
      while (expQ.size() != 0 && waited < 20) begin
         @(negedge clk);
         driveRandom(1'b0, 1'b1, 1'b1);
         observeCycle();
         waited++;
      end
      if (expQ.size() != 0) begin
         $display("Timed out waiting for %0d outstanding bundles to drain", expQ.size());
         otherErrors++;
      end
      $display("Summary: %0d in, %0d out, %0d value errors, %0d other errors",
               inCount, outCount, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0 && inCount == outCount)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== wiscDecode.f ====
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/decodeControl.sv
source/regFile.sv
source/operandForward.sv
source/branchResolve.sv
source/wiscDecode.sv
testbench/wiscDecodeTb.sv
